/* Bender.yml */
package:
  name: zports

sources:
  - files:
      - hdl/zports_pkg.sv
      - hdl/port_decode.sv
      - hdl/config_regs.sv
      - hdl/fdd_port.sv
      - hdl/port_read_mux.sv
      - hdl/zports_top.sv
  - target: test
    files:
      - testbench/zports_checker.sv
      - testbench/tb_zports.sv

/* hdl/config_regs.sv */
// configuration registers: extended AF registers, 7FFD paging with lock modes, SD chip select
`timescale 1ns/1ps

module config_regs
#(
	parameter zports_pkg::data_t  MEMCONF_RESET = 8'h04,
	parameter zports_pkg::vmask_t FDDVIRT_RESET = 4'b0001
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  zports_pkg::data_t    din,
	input  logic                 opfetch,
	input  logic                 xt_wr,
	input  zports_pkg::port_hi_t xt_idx,
	input  logic                 p7ffd_wr,
	input  logic                 sdcfg_wr,
	output logic [31:0]          xt_page,
	output zports_pkg::data_t    sysconf,
	output zports_pkg::data_t    memconf,
	output logic [3:0]           cacheconf,
	output zports_pkg::vmask_t   fddvirt,
	output zports_pkg::data_t    intmask,
	output logic                 sdcs_n,
	output logic                 lock48
);
	import zports_pkg::*;

	page_t rampage [4];
	logic  m1_lock128;  // captured from the opcode byte
	logic  lock_mode2;
	logic  lock_mode3;
	logic  lock128;     // 128K paging bits held at zero

	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

	// --------------------------------------------------
	// 7FFD lock modes, memconf[7:6]
	// --------------------------------------------------
	assign lock_mode2 = (memconf[7:6] == 2'b10);
	assign lock_mode3 = (memconf[7:6] == 2'b11); // pentagon 1024 style, no lock
	assign lock128 = lock_mode3 ? 1'b0 : (lock_mode2 ? m1_lock128 : memconf[6]);

	always_ff @(posedge clk)
	begin
		if (rst)
			m1_lock128 <= 1'b0;
		else if (opfetch)
			m1_lock128 <= (din[7] == din[6]);
	end

	// --------------------------------------------------
	// paging and config registers
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sysconf    <= 8'h01; // 7 MHz turbo
			memconf    <= MEMCONF_RESET;
			cacheconf  <= 4'h0;
			fddvirt    <= FDDVIRT_RESET;
			intmask    <= 8'h01; // frame int only
			rampage[0] <= 8'h00;
			rampage[1] <= 8'h05; // screen page
			rampage[2] <= 8'h02;
			rampage[3] <= 8'h00;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= din[4]; // ROM select
			if (lock_mode3)
				rampage[3] <= {2'b00, din[5], din[7:6], din[2:0]};
			else
				rampage[3] <= {3'b000, (lock128 ? 2'b00 : din[7:6]), din[2:0]};
		end
		else if (xt_wr)
		begin
			if (xt_idx[7:2] == XT_RAMPAGE[7:2])
				rampage[xt_idx[1:0]] <= din;
			if (xt_idx == XT_SYSCONF)
			begin
				sysconf   <= din;
				cacheconf <= {4{din[2]}}; // cache follows turbo bit
			end
			if (xt_idx == XT_CACHECONF)
				cacheconf <= din[3:0];
			if (xt_idx == XT_MEMCONF)
				memconf <= din;
			if (xt_idx == XT_FDDVIRT)
				fddvirt <= din[3:0];
			if (xt_idx == XT_INTMASK)
				intmask <= din;
		end
	end

	// 48K lock, not used in mode 3
	always_ff @(posedge clk)
	begin
		if (rst)
			lock48 <= 1'b0;
		else if (p7ffd_wr && !lock_mode3)
			lock48 <= din[5];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;
		else if (sdcfg_wr)
			sdcs_n <= din[1];
	end

	// 7FFD never reaches pages above 63
	a_7ffd_page_range: assert property (@(posedge clk) disable iff (rst)
		p7ffd_wr |=> (xt_page[31:30] == 2'b00));

endmodule

/* hdl/fdd_port.sv */
// floppy controller port with chip select, drive select register and virtual DOS entry and exit
`timescale 1ns/1ps

module fdd_port
(
	input  logic               clk,
	input  zports_pkg::data_t  din,
	input  logic               dos,
	input  logic               vdos,
	input  logic               iorw,
	input  logic               wr,
	input  logic               rdwr,
	input  logic               iorq_s,
	input  logic               iowr_s,
	input  logic               vg_hit,
	input  logic               vgsys_hit,
	input  logic               vgsys_wr,
	input  zports_pkg::vmask_t fddvirt,
	output zports_pkg::drive_t drive_sel,
	output logic               vg_cs_n,
	output logic               vg_wrff,
	output logic               vdos_on,
	output logic               vdos_off
);

	logic virt_vg;  // selected drive is emulated
	logic real_vg;  // real controller owns the access

	assign virt_vg = fddvirt[drive_sel];
	assign real_vg = dos && !vdos && !virt_vg;

	assign vg_cs_n = !(iorw && vg_hit && real_vg);
	assign vg_wrff = wr && iorq_s && vgsys_hit && real_vg; // system port write to real chip

	// trap into virtual DOS, and back out on any controller access from there
	assign vdos_on  = rdwr && iorq_s && (vg_hit || vgsys_hit) && dos && !vdos && virt_vg;
	assign vdos_off = rdwr && iorq_s && vg_hit && vdos;

	always_ff @(posedge clk)
	begin
		if (vgsys_wr)
			drive_sel <= din[1:0];
	end

	a_vdos_excl: assert property (@(posedge clk) !(vdos_on && vdos_off));

endmodule

/* hdl/port_decode.sv */
// port decoder: turns CPU port address, DOS state and I/O strobes into hits and write strobes
`timescale 1ns/1ps

module port_decode
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [15:0]          a,
	input  logic                 dos,
	input  logic                 vdos,
	input  logic                 iowr_s,
	input  logic                 iord_s,
	input  logic                 iorw,
	input  logic                 wr,
	input  logic                 rdwr,
	input  logic                 lock48,
	output logic                 porthit,
	output logic                 external_port,
	output logic                 dataout_en,
	output logic                 xt_wr,
	output zports_pkg::port_hi_t xt_idx,
	output logic                 p7ffd_wr,
	output logic                 sdcfg_wr,
	output logic                 sd_start,
	output logic                 vg_hit,
	output logic                 vgsys_hit,
	output logic                 vgsys_wr
);
	import zports_pkg::*;

	port_lo_t loa;
	logic     iord;   // read cycle level
	logic     sd_ok;  // SD ports visible outside DOS or in virtual DOS
	logic     sdcfg_hit;
	logic     sddat_hit;

	assign loa    = a[7:0];
	assign xt_idx = a[15:8];
	assign iord   = iorw && rdwr && !wr;

	// --------------------------------------------------
	// hit flags
	// --------------------------------------------------
	assign vg_hit = (loa == PORT_VGCOM) || (loa == PORT_VGTRK) ||
		(loa == PORT_VGSEC) || (loa == PORT_VGDAT);
	assign vgsys_hit = (loa == PORT_VGSYS);

	assign sd_ok     = !dos || vdos;
	assign sdcfg_hit = (loa == PORT_SDCFG) && sd_ok;
	assign sddat_hit = (loa == PORT_SDDAT) && sd_ok;

	assign porthit = (loa == PORT_FE) || (loa == PORT_XT) || (loa == PORT_FD) ||
		(loa == PORT_COVOX) ||
		((vg_hit || vgsys_hit) && dos) ||
		((loa == PORT_KJOY) && !dos) ||
		(loa == PORT_KMOUSE) ||
		sdcfg_hit || sddat_hit;

	// AY above 7FFD and the real floppy chip are served outside
	assign external_port = ((loa == PORT_FD) && a[15]) || (vg_hit && dos);

	assign dataout_en = porthit && iord && !external_port;

	// --------------------------------------------------
	// write strobes
	// --------------------------------------------------
	assign xt_wr    = iowr_s && (loa == PORT_XT);
	assign p7ffd_wr = iowr_s && (loa == PORT_FD) && !a[15] && !lock48; // 48K lock freezes paging
	assign sdcfg_wr = iowr_s && sdcfg_hit;
	assign vgsys_wr = iowr_s && vgsys_hit && dos; // drive number

	assign sd_start = sddat_hit && (iowr_s || iord_s); // one SPI byte per access

	// the two paging paths into config_regs must not collide
	a_xt_7ffd_excl: assert property (@(posedge clk) disable iff (rst)
		!(xt_wr && p7ffd_wr));

endmodule

/* hdl/port_read_mux.sv */
// port read multiplexer: returns data for the internal readable ports
`timescale 1ns/1ps

module port_read_mux
(
	input  zports_pkg::port_lo_t port_lo,
	input  zports_pkg::port_hi_t port_hi,
	input  logic [31:0]          xt_page,
	input  logic [4:0]           keys_in,
	input  logic                 tape_read,
	input  logic [5:0]           kj_in,
	input  logic [7:0]           mus_in,
	input  logic                 vg_intrq,
	input  logic                 vg_drq,
	input  zports_pkg::data_t    sd_dataout,
	output zports_pkg::data_t    dout
);
	import zports_pkg::*;

	data_t xt_dout;

	// only the upper two page registers read back
	always_comb
	begin
		if (port_hi == XT_RAMPAGE + 8'd2)
			xt_dout = xt_page[23:16];
		else if (port_hi == XT_RAMPAGE + 8'd3)
			xt_dout = xt_page[31:24];
		else
			xt_dout = 8'hFF;
	end

	always_comb
	begin
		case (port_lo)
			PORT_FE:
				dout = {1'b1, tape_read, 1'b1, keys_in};
			PORT_XT:
				dout = xt_dout;
			PORT_VGSYS:
				dout = {vg_intrq, vg_drq, 6'b111111};
			PORT_KJOY:
				dout = {2'b00, kj_in};
			PORT_KMOUSE:
				dout = mus_in;
			PORT_SDCFG:
				dout = 8'h00; // card present, not write protected
			PORT_SDDAT:
				dout = sd_dataout;
			default:
				dout = 8'hFF;
		endcase
	end

endmodule

/* hdl/zports_pkg.sv */
// zports shared definitions: port addresses, extended register indexes and bus types
package zports_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int DATA_W  = 8;
	localparam int VMASK_W = 4; // one bit per floppy drive
	localparam int DRIVE_W = 2;

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [DATA_W-1:0]  port_lo_t; // selects the port
	typedef logic [DATA_W-1:0]  port_hi_t; // selects the extended register
	typedef logic [DATA_W-1:0]  page_t;
	typedef logic [VMASK_W-1:0] vmask_t;
	typedef logic [DRIVE_W-1:0] drive_t;

	// --------------------------------------------------
	// low byte port addresses
	// --------------------------------------------------
	localparam port_lo_t PORT_FE     = 8'hFE; // keyboard, tape
	localparam port_lo_t PORT_FD     = 8'hFD; // 7FFD paging, AY above
	localparam port_lo_t PORT_XT     = 8'hAF; // extended config
	localparam port_lo_t PORT_COVOX  = 8'hFB;

	// floppy controller group, DOS only
	localparam port_lo_t PORT_VGCOM  = 8'h1F;
	localparam port_lo_t PORT_VGTRK  = 8'h3F;
	localparam port_lo_t PORT_VGSEC  = 8'h5F;
	localparam port_lo_t PORT_VGDAT  = 8'h7F;
	localparam port_lo_t PORT_VGSYS  = 8'hFF;

	localparam port_lo_t PORT_KJOY   = 8'h1F; // shares 1F with VGCOM outside DOS
	localparam port_lo_t PORT_KMOUSE = 8'hDF;

	// SD card SPI
	localparam port_lo_t PORT_SDCFG  = 8'h77;
	localparam port_lo_t PORT_SDDAT  = 8'h57;

	// --------------------------------------------------
	// extended register indexes (high byte at port AF)
	// --------------------------------------------------
	localparam port_hi_t XT_RAMPAGE   = 8'h10; // 10..13
	localparam port_hi_t XT_SYSCONF   = 8'h20;
	localparam port_hi_t XT_MEMCONF   = 8'h21;
	localparam port_hi_t XT_FDDVIRT   = 8'h29;
	localparam port_hi_t XT_INTMASK   = 8'h2A;
	localparam port_hi_t XT_CACHECONF = 8'h2B;

endpackage

/* hdl/zports_top.sv */
// zports top: I/O port block, decoder wired to config, floppy and read datapaths
`timescale 1ns/1ps

module zports_top
#(
	parameter zports_pkg::data_t  MEMCONF_RESET = 8'h04,
	parameter zports_pkg::vmask_t FDDVIRT_RESET = 4'b0001
)
(
	input  logic               clk,
	input  logic               rst,
	input  logic [15:0]        a,
	input  zports_pkg::data_t  din,
	input  logic               dos,
	input  logic               vdos,
	input  logic               iorw,
	input  logic               iowr_s,
	input  logic               iord_s,
	input  logic               wr,
	input  logic               rdwr,
	input  logic               opfetch,
	input  logic [4:0]         keys_in,
	input  logic               tape_read,
	input  logic [5:0]         kj_in,
	input  logic [7:0]         mus_in,
	input  logic               vg_intrq,
	input  logic               vg_drq,
	input  zports_pkg::data_t  sd_dataout,
	output logic               porthit,
	output logic               external_port,
	output logic               dataout,
	output zports_pkg::data_t  dout,
	output logic [31:0]        xt_page,
	output zports_pkg::data_t  sysconf,
	output zports_pkg::data_t  memconf,
	output logic [3:0]         cacheconf,
	output zports_pkg::vmask_t fddvirt,
	output zports_pkg::data_t  intmask,
	output logic               sdcs_n,
	output logic               lock48,
	output logic               sd_start,
	output zports_pkg::drive_t drive_sel,
	output logic               vg_cs_n,
	output logic               vg_wrff,
	output logic               vdos_on,
	output logic               vdos_off
);
	import zports_pkg::*;

	logic     xt_wr;
	port_hi_t xt_idx;
	logic     p7ffd_wr;
	logic     sdcfg_wr;
	logic     vg_hit;
	logic     vgsys_hit;
	logic     vgsys_wr;

	port_decode u_decode (
		.clk(clk), .rst(rst), .a(a), .dos(dos), .vdos(vdos),
		.iowr_s(iowr_s), .iord_s(iord_s), .iorw(iorw), .wr(wr), .rdwr(rdwr),
		.lock48(lock48), .porthit(porthit), .external_port(external_port),
		.dataout_en(dataout), .xt_wr(xt_wr), .xt_idx(xt_idx), .p7ffd_wr(p7ffd_wr),
		.sdcfg_wr(sdcfg_wr), .sd_start(sd_start), .vg_hit(vg_hit),
		.vgsys_hit(vgsys_hit), .vgsys_wr(vgsys_wr)
	);

	config_regs #(
		.MEMCONF_RESET(MEMCONF_RESET),
		.FDDVIRT_RESET(FDDVIRT_RESET)
	) u_config (
		.clk(clk), .rst(rst), .din(din), .opfetch(opfetch),
		.xt_wr(xt_wr), .xt_idx(xt_idx), .p7ffd_wr(p7ffd_wr), .sdcfg_wr(sdcfg_wr),
		.xt_page(xt_page), .sysconf(sysconf), .memconf(memconf),
		.cacheconf(cacheconf), .fddvirt(fddvirt), .intmask(intmask),
		.sdcs_n(sdcs_n), .lock48(lock48)
	);

	// any I/O strobe counts as the access strobe here
	fdd_port u_fdd (
		.clk(clk), .din(din), .dos(dos), .vdos(vdos), .iorw(iorw), .wr(wr),
		.rdwr(rdwr), .iorq_s(iowr_s | iord_s), .iowr_s(iowr_s),
		.vg_hit(vg_hit), .vgsys_hit(vgsys_hit), .vgsys_wr(vgsys_wr),
		.fddvirt(fddvirt), .drive_sel(drive_sel), .vg_cs_n(vg_cs_n),
		.vg_wrff(vg_wrff), .vdos_on(vdos_on), .vdos_off(vdos_off)
	);

	port_read_mux u_rdmux (
		.port_lo(a[7:0]), .port_hi(a[15:8]), .xt_page(xt_page),
		.keys_in(keys_in), .tape_read(tape_read), .kj_in(kj_in), .mus_in(mus_in),
		.vg_intrq(vg_intrq), .vg_drq(vg_drq), .sd_dataout(sd_dataout), .dout(dout)
	);

endmodule

/* project.f */
hdl/zports_pkg.sv
hdl/port_decode.sv
hdl/config_regs.sv
hdl/fdd_port.sv
hdl/port_read_mux.sv
hdl/zports_top.sv
testbench/zports_checker.sv
testbench/tb_zports.sv

/* testbench/tb_zports.sv */
// port block testbench with clock, reset, seeded random stimulus and test sequence
`timescale 1ns/1ps

module tb_zports;

	localparam logic [7:0] MEMCONF_RESET = 8'h04;
	localparam logic [3:0] FDDVIRT_RESET = 4'b0001;
	localparam int         SEED          = 83784;
	localparam int         LOCK_TRIES    = 64; // 7FFD writes allowed before lock48 must be set
	localparam int         IDLE          = 0;
	localparam int         READ          = 1;
	localparam int         WRITE         = 2;

	logic        clk = 1'b0;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  din;
	logic        dos, vdos;
	logic        iorw, iowr_s, iord_s, wr, rdwr, opfetch;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [5:0]  kj_in;
	logic [7:0]  mus_in;
	logic        vg_intrq, vg_drq;
	logic [7:0]  sd_dataout;
	logic        porthit, external_port, dataout;
	logic [7:0]  dout;
	logic [31:0] xt_page;
	logic [7:0]  sysconf, memconf, intmask;
	logic [3:0]  cacheconf, fddvirt;
	logic        sdcs_n, lock48, sd_start;
	logic [1:0]  drive_sel;
	logic        vg_cs_n, vg_wrff, vdos_on, vdos_off;
	int          errors;
	int          checks;
	logic        timed_out = 1'b0;

	always #20 clk = ~clk;

	zports_top u_dut (.*);

	zports_checker #(
		.MEMCONF_RESET(MEMCONF_RESET),
		.FDDVIRT_RESET(FDDVIRT_RESET)
	) u_check (.*);

	// --------------------------------------------------
	// bus cycle tasks
	// --------------------------------------------------
	task automatic drive_cycle(input int kind, input logic [15:0] addr, input logic [7:0] data,
		input logic dos_v, input logic vdos_v, input logic op);
		@(posedge clk);
		#2;
		a          = addr;
		din        = data;
		dos        = dos_v;
		vdos       = vdos_v;
		opfetch    = op;
		iorw       = (kind != IDLE);
		rdwr       = (kind != IDLE);
		wr         = (kind == WRITE);
		iowr_s     = (kind == WRITE);
		iord_s     = (kind == READ);
		keys_in    = 5'($urandom);
		tape_read  = 1'($urandom);
		kj_in      = 6'($urandom);
		mus_in     = 8'($urandom);
		vg_intrq   = 1'($urandom);
		vg_drq     = 1'($urandom);
		sd_dataout = 8'($urandom);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data,
		input logic dos_v, input logic vdos_v);
		drive_cycle(WRITE, addr, data, dos_v, vdos_v, 1'b0);
		drive_cycle(IDLE, addr, data, dos_v, vdos_v, 1'b0);
	endtask

	task automatic io_read(input logic [15:0] addr, input logic dos_v, input logic vdos_v);
		drive_cycle(READ, addr, 8'($urandom), dos_v, vdos_v, 1'b0);
		drive_cycle(IDLE, addr, 8'($urandom), dos_v, vdos_v, 1'b0);
	endtask

	task automatic opfetch_cycle(input logic [7:0] data);
		drive_cycle(IDLE, a, data, dos, vdos, 1'b1);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst = 1'b1;
		repeat (16)
			drive_cycle(IDLE, 16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		rst = 1'b0;
	endtask

	// ports worth hitting more often than a flat random address would
	function automatic logic [7:0] port_at(input int unsigned i);
		case (i)
			0: return 8'hFE;
			1: return 8'hFD;
			2: return 8'hAF;
			3: return 8'hFB;
			4: return 8'h1F;
			5: return 8'h3F;
			6: return 8'h5F;
			7: return 8'h7F;
			8: return 8'hFF;
			9: return 8'hDF;
			10: return 8'h77;
			11: return 8'h57;
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic [7:0] xt_index_at(input int unsigned i);
		case (i)
			0, 1, 2, 3: return 8'h10 + 8'(i); // page registers
			4: return 8'h20;
			5: return 8'h21;
			6: return 8'h29;
			7: return 8'h2A;
			default: return 8'h2B;
		endcase
	endfunction

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_reset();
		apply_reset();
		repeat (4)
			drive_cycle(IDLE, 16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		// drive select has no reset so it is loaded before floppy decode matters
		io_write(16'h00FF, 8'($urandom), 1'b1, 1'b0);
	endtask

	task automatic test_xt_regs();
		logic [7:0] idx;
		repeat (60)
		begin
			idx = xt_index_at($urandom % 9);
			io_write({idx, 8'hAF}, 8'($urandom), 1'b0, 1'b0);
			if ($urandom % 2)
				idx = 8'h12 + 8'($urandom % 2);
			else
				idx = 8'($urandom);
			io_read({idx, 8'hAF}, 1'b0, 1'b0);
		end
	endtask

	task automatic paging_write();
		opfetch_cycle(8'($urandom));
		io_write({1'b0, 7'($urandom), 8'hFD}, 8'($urandom), 1'b0, 1'b0);
	endtask

	task automatic test_paging();
		int m;
		int tries;
		for (m = 0; m < 4; m++)
		begin
			apply_reset();
			io_write(16'h21AF, {2'(m), 6'($urandom)}, 1'b0, 1'b0); // lock mode into memconf
			if (m == 3)
			begin
				repeat (16)
					paging_write();
			end
			else
			begin
				tries = 0;
				while (lock48 !== 1'b1 && tries < LOCK_TRIES)
				begin
					paging_write();
					tries++;
				end
				if (lock48 !== 1'b1)
				begin
					$display("timeout: lock48 never set in lock mode %0d", m);
					timed_out = 1'b1;
				end
				repeat (4)
					paging_write(); // frozen by the 48K lock
			end
		end
		apply_reset();
	endtask

	task automatic test_decode();
		logic [15:0] addr;
		repeat (300)
		begin
			addr = 16'($urandom);
			if ($urandom % 4 != 0)
				addr[7:0] = port_at($urandom % 13);
			drive_cycle($urandom % 3, addr, 8'($urandom), 1'($urandom), 1'($urandom),
				1'($urandom));
		end
	endtask

	task automatic test_floppy();
		logic [15:0] addr;
		repeat (24)
		begin
			io_write(16'h29AF, 8'($urandom), 1'b0, 1'b0);
			io_write({8'($urandom), 8'hFF}, 8'($urandom), 1'b1, 1'b0);
			repeat (6)
			begin
				addr = {8'($urandom), port_at(4 + $urandom % 5)}; // controller group
				drive_cycle(1 + $urandom % 2, addr, 8'($urandom), 1'($urandom),
					1'($urandom), 1'b0);
			end
		end
	endtask

	task automatic test_read_ports();
		repeat (60)
			io_read({8'($urandom), port_at($urandom % 13)}, 1'($urandom), 1'($urandom));
		repeat (20)
		begin
			io_write({8'($urandom), 8'h77}, 8'($urandom), 1'b0, 1'b0);
			io_write({8'($urandom), 8'h57}, 8'($urandom), 1'b0, 1'($urandom));
			io_read({8'($urandom), 8'h57}, 1'($urandom), 1'b1);
		end
	endtask

	task automatic report_test(input string name, input int mark);
		$display("test %0s: %0d errors", name, errors - mark);
	endtask

	initial
	begin
		int mark;
		void'($urandom(SEED));
		rst = 1'b1;
		a = 16'h0000;
		din = 8'h00;
		dos = 1'b0;
		vdos = 1'b0;
		{iorw, iowr_s, iord_s, wr, rdwr, opfetch} = 6'b000000;
		keys_in = 5'h1F;
		tape_read = 1'b0;
		kj_in = 6'h00;
		mus_in = 8'hFF;
		{vg_intrq, vg_drq} = 2'b00;
		sd_dataout = 8'hFF;

		mark = errors;
		test_reset();
		report_test("reset", mark);
		mark = errors;
		test_xt_regs();
		report_test("xt_regs", mark);
		mark = errors;
		test_paging();
		report_test("paging", mark);
		mark = errors;
		test_decode();
		report_test("decode", mark);
		mark = errors;
		test_floppy();
		report_test("floppy", mark);
		mark = errors;
		test_read_ports();
		report_test("read_ports", mark);

		drive_cycle(IDLE, 16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* testbench/zports_checker.sv */
// port block checker: reference model of registers, paging locks and decode, compared each cycle
`timescale 1ns/1ps

module zports_checker
#(
	parameter logic [7:0] MEMCONF_RESET = 8'h04,
	parameter logic [3:0] FDDVIRT_RESET = 4'b0001
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        dos, vdos,
	input  logic        iorw, iowr_s, iord_s, wr, rdwr, opfetch,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [5:0]  kj_in,
	input  logic [7:0]  mus_in,
	input  logic        vg_intrq, vg_drq,
	input  logic [7:0]  sd_dataout,
	input  logic        porthit, external_port, dataout,
	input  logic [7:0]  dout,
	input  logic [31:0] xt_page,
	input  logic [7:0]  sysconf, memconf, intmask,
	input  logic [3:0]  cacheconf, fddvirt,
	input  logic        sdcs_n, lock48, sd_start,
	input  logic [1:0]  drive_sel,
	input  logic        vg_cs_n, vg_wrff, vdos_on, vdos_off,
	output int          errors,
	output int          checks
);

	logic [7:0] rp [4];  // model page registers
	logic [7:0] m_sysconf, m_memconf, m_intmask;
	logic [3:0] m_cache, m_fddvirt;
	logic       m_sdcs_n, m_lock48, m_m1lock;
	logic [1:0] m_drive;
	logic       drive_known = 1'b0;
	logic       valid = 1'b0; // set by the first reset edge

	initial
	begin
		errors = 0;
		checks = 0;
	end

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR t=%0t %0s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	// --------------------------------------------------
	// register model, stepped on the rising edge
	// --------------------------------------------------
	task automatic reset_model();
		rp[0] = 8'h00;
		rp[1] = 8'h05;
		rp[2] = 8'h02;
		rp[3] = 8'h00;
		m_sysconf = 8'h01;
		m_memconf = MEMCONF_RESET;
		m_cache = 4'h0;
		m_fddvirt = FDDVIRT_RESET;
		m_intmask = 8'h01;
		m_sdcs_n = 1'b1;
		m_lock48 = 1'b0;
		m_m1lock = 1'b0;
		valid = 1'b1;
	endtask

	task automatic update_model();
		logic [7:0] lo;
		lo = a[7:0];
		// paging uses the lock captured before this edge
		if (iowr_s && lo == 8'hFD && !a[15] && !m_lock48)
		begin
			case (m_memconf[7:6])
				2'b11: rp[3] = {2'b00, din[5], din[7:6], din[2:0]};
				2'b10: rp[3] = {3'b000, (m_m1lock ? 2'b00 : din[7:6]), din[2:0]};
				default: rp[3] = {3'b000, (m_memconf[6] ? 2'b00 : din[7:6]), din[2:0]};
			endcase
			if (m_memconf[7:6] != 2'b11)
				m_lock48 = din[5];
			m_memconf[0] = din[4];
		end
		if (iowr_s && lo == 8'hAF)
		begin
			case (a[15:8])
				8'h10, 8'h11, 8'h12, 8'h13: rp[a[9:8]] = din;
				8'h20:
				begin
					m_sysconf = din;
					m_cache = {4{din[2]}};
				end
				8'h21: m_memconf = din;
				8'h29: m_fddvirt = din[3:0];
				8'h2A: m_intmask = din;
				8'h2B: m_cache = din[3:0];
				default: ;
			endcase
		end
		if (iowr_s && lo == 8'h77 && (!dos || vdos))
			m_sdcs_n = din[1];
		if (opfetch)
			m_m1lock = (din[7] == din[6]);
	endtask

	always @(posedge clk)
	begin
		if (rst)
			reset_model();
		else if (valid)
			update_model();
		if (iowr_s && a[7:0] == 8'hFF && dos) // drive select ignores reset
		begin
			m_drive = din[1:0];
			drive_known = 1'b1;
		end
	end

	// --------------------------------------------------
	// expected outputs, sampled mid cycle
	// --------------------------------------------------
	function automatic logic [7:0] read_value(input logic [7:0] lo, input logic [7:0] hi);
		case (lo)
			8'hFE: return {1'b1, tape_read, 1'b1, keys_in};
			8'hAF: return (hi == 8'h12) ? rp[2] : ((hi == 8'h13) ? rp[3] : 8'hFF);
			8'hFF: return {vg_intrq, vg_drq, 6'h3F};
			8'h1F: return {2'b00, kj_in};
			8'hDF: return mus_in;
			8'h77: return 8'h00;
			8'h57: return sd_dataout;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic check_outputs();
		logic [7:0] lo;
		logic       vg4, sd_ok, hit, ext, strobe, virt, real_fdd;
		lo = a[7:0];
		vg4 = (lo == 8'h1F) || (lo == 8'h3F) || (lo == 8'h5F) || (lo == 8'h7F);
		sd_ok = !dos || vdos;
		strobe = iowr_s || iord_s;
		hit = (lo == 8'hFE) || (lo == 8'hAF) || (lo == 8'hFD) || (lo == 8'hFB) ||
			(lo == 8'hDF) || (lo == 8'h1F) || ((vg4 || lo == 8'hFF) && dos) ||
			(((lo == 8'h77) || (lo == 8'h57)) && sd_ok);
		ext = ((lo == 8'hFD) && a[15]) || (vg4 && dos); // AY and real controller
		compare_value("porthit", hit, porthit);
		compare_value("external_port", ext, external_port);
		compare_value("dataout", hit && !ext && iorw && rdwr && !wr, dataout);
		compare_value("sd_start", (lo == 8'h57) && sd_ok && strobe, sd_start);
		compare_value("dout", read_value(lo, a[15:8]), dout);
		compare_value("xt_page", {rp[3], rp[2], rp[1], rp[0]}, xt_page);
		compare_value("sysconf", m_sysconf, sysconf);
		compare_value("memconf", m_memconf, memconf);
		compare_value("cacheconf", m_cache, cacheconf);
		compare_value("fddvirt", m_fddvirt, fddvirt);
		compare_value("intmask", m_intmask, intmask);
		compare_value("sdcs_n", m_sdcs_n, sdcs_n);
		compare_value("lock48", m_lock48, lock48);
		if (drive_known)
		begin
			virt = m_fddvirt[m_drive];
			real_fdd = dos && !vdos && !virt;
			compare_value("drive_sel", m_drive, drive_sel);
			compare_value("vg_cs_n", !(iorw && vg4 && real_fdd), vg_cs_n);
			compare_value("vg_wrff", wr && strobe && (lo == 8'hFF) && real_fdd, vg_wrff);
			compare_value("vdos_on",
				rdwr && strobe && (vg4 || lo == 8'hFF) && dos && !vdos && virt, vdos_on);
			compare_value("vdos_off", rdwr && strobe && vg4 && vdos, vdos_off);
		end
	endtask

	always @(negedge clk)
	begin
		if (valid)
			check_outputs();
	end

endmodule
